//--- verilog/rvCoreParams.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// first fetch address once run rises
`define RESET_PC 64'h0

// word address width of the unified memory
`define MEM_AW 10

// prefetch queue entries
`define IQ_DEPTH 2

`endif

//--- verilog/rvCorePkg.sv
`include "rvCoreParams.svh"

package rvCorePkg;

    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_RETURN_B = 4'd1   // pass operand b, lui
    } aluOp_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'b00,
        WB_PC4 = 2'b10        // link value for jal
    } wbSel_e;

    typedef struct packed {
        aluOp_e      aluOperate;
        logic        selA;    // 1: rs1, 0: pc
        logic        selB;    // 1: rs2, 0: imm
        logic        writeRd;
        logic        isJump;
        logic        isStore;
        logic [7:0]  storeMask;
        wbSel_e      wbSel;
        logic        isEbreak;
        logic [63:0] imm;
    } decodeCtrl_t;

    typedef struct packed {
        logic               req;
        logic               we;
        logic [`MEM_AW-1:0] addr;
        logic [63:0]        wdata;
        logic [7:0]         mask;
    } memReq_t;

endpackage

//--- verilog/memBusIf.sv
`timescale 1ns/10ps

interface memBusIf;

    rvCorePkg::memReq_t req;
    logic               gnt;
    logic [63:0]        rdata;   // valid the cycle after a read grant

    modport requester
    (
        output req,
        input  gnt,
        input  rdata
    );

    modport arbiter
    (
        input  req,
        output gnt,
        output rdata
    );

endinterface

//--- verilog/instDecoder.sv
`timescale 1ns/10ps

module instDecoder
(
    input  logic [31:0]            inst,
    output rvCorePkg::decodeCtrl_t ctrl
);

    logic [6:0]  opCode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [63:0] immI;
    logic [63:0] immS;
    logic [63:0] immU;
    logic [63:0] immJ;

    assign opCode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb
    begin
        ctrl = '0;
        ctrl.aluOperate = rvCorePkg::ALU_ADD;
        ctrl.wbSel = rvCorePkg::WB_ALU;
        case (opCode)
            7'b0110011:   // add
            begin
                ctrl.selA = 1'b1;
                ctrl.selB = 1'b1;
                ctrl.writeRd = (funct3 == 3'b000) && (funct7 == 7'b0);
            end
            7'b0010011:   // addi
            begin
                ctrl.selA = 1'b1;
                ctrl.imm = immI;
                ctrl.writeRd = (funct3 == 3'b000);
            end
            7'b0010111:   // auipc
            begin
                ctrl.imm = immU;
                ctrl.writeRd = 1'b1;
            end
            7'b0110111:   // lui
            begin
                ctrl.aluOperate = rvCorePkg::ALU_RETURN_B;
                ctrl.imm = immU;
                ctrl.writeRd = 1'b1;
            end
            7'b1101111:   // jal, alu forms the target
            begin
                ctrl.imm = immJ;
                ctrl.isJump = 1'b1;
                ctrl.writeRd = 1'b1;
                ctrl.wbSel = rvCorePkg::WB_PC4;
            end
            7'b0100011:
            begin
                ctrl.selA = 1'b1;
                ctrl.imm = immS;
                ctrl.isStore = !funct3[2];
                case (funct3)
                    3'b000:  ctrl.storeMask = 8'b0000_0001;
                    3'b001:  ctrl.storeMask = 8'b0000_0011;
                    3'b010:  ctrl.storeMask = 8'b0000_1111;
                    3'b011:  ctrl.storeMask = 8'b1111_1111;
                    default: ctrl.storeMask = 8'b0;
                endcase
            end
            7'b1110011:
            begin
                ctrl.isEbreak = (funct3 == 3'b000) && (immI == 64'd1);
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/fetchUnit.sv
`timescale 1ns/10ps
`include "rvCoreParams.svh"

module fetchUnit
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        run,
    input  logic        halted,
    input  logic        deq,
    input  logic        redirect,
    input  logic [63:0] redirectPc,
    output logic        instValid,
    output logic [31:0] instWord,
    output logic [63:0] instPc,
    memBusIf.requester  bus
);

    localparam int PtrW = (`IQ_DEPTH > 1) ? $clog2(`IQ_DEPTH) : 1;
    localparam int CntW = $clog2(`IQ_DEPTH + 1);

    logic [63:0]     pc;
    logic [63:0]     respPc;
    logic            inFlight;
    logic            epoch;
    logic            respEpoch;
    logic [31:0]     qInst [`IQ_DEPTH];
    logic [63:0]     qPc [`IQ_DEPTH];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [CntW-1:0] count;
    logic            reqOn;
    logic            granted;
    logic            push;
    logic            pop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        nextPtr = (ptr == PtrW'(`IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // in-flight response already owns a slot
    assign reqOn = run && !halted && ((count + CntW'(inFlight)) < CntW'(`IQ_DEPTH));
    assign granted = reqOn && bus.gnt;
    assign push = run && inFlight && (respEpoch == epoch) && !redirect;  // stale epoch dropped
    assign pop = deq && instValid;

    always_comb
    begin
        bus.req.req = reqOn;
        bus.req.we = 1'b0;
        bus.req.addr = pc[`MEM_AW+2:3];
        bus.req.wdata = '0;
        bus.req.mask = '0;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc <= `RESET_PC;
            inFlight <= 1'b0;
            epoch <= 1'b0;
            respEpoch <= 1'b0;
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else
        begin
            inFlight <= granted;
            if (granted)
                respEpoch <= epoch;
            if (!run)
            begin
                pc <= `RESET_PC;
                rdPtr <= '0;
                wrPtr <= '0;
                count <= '0;
            end
            else if (redirect)
            begin
                pc <= redirectPc;
                epoch <= ~epoch;
                rdPtr <= '0;
                wrPtr <= '0;
                count <= '0;
            end
            else
            begin
                if (granted)
                    pc <= pc + 64'd4;
                if (push)
                    wrPtr <= nextPtr(wrPtr);
                if (pop)
                    rdPtr <= nextPtr(rdPtr);
                count <= count + CntW'(push) - CntW'(pop);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (granted)
            respPc <= pc;
        if (push)
        begin
            qInst[wrPtr] <= respPc[2] ? bus.rdata[63:32] : bus.rdata[31:0];
            qPc[wrPtr] <= respPc;
        end
    end

    assign instValid = (count != '0);
    assign instWord = qInst[rdPtr];
    assign instPc = qPc[rdPtr];

endmodule

//--- verilog/execUnit.sv
`timescale 1ns/10ps
`include "rvCoreParams.svh"

module execUnit
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        instValid,
    input  logic [31:0] instWord,
    input  logic [63:0] instPc,
    output logic        deq,
    output logic        redirect,
    output logic [63:0] redirectPc,
    output logic        halted,
    output logic        retireValid,
    output logic [63:0] retirePc,
    output logic        retireRdWe,
    output logic [4:0]  retireRd,
    output logic [63:0] retireRdData,
    output logic        storeValid,
    output logic [63:0] storeAddr,
    output logic [63:0] storeData,
    output logic [7:0]  storeMask,
    memBusIf.requester  bus
);

    rvCorePkg::decodeCtrl_t ctrl;

    logic [63:0] regs [1:31];
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [63:0] rs1Val;
    logic [63:0] rs2Val;
    logic [63:0] opA;
    logic [63:0] opB;
    logic [63:0] aluOut;
    logic [63:0] wbData;
    logic        active;

    instDecoder decoder
    (
        .inst (instWord),
        .ctrl (ctrl)
    );

    assign rs1 = instWord[19:15];
    assign rs2 = instWord[24:20];
    assign rd = instWord[11:7];
    assign rs1Val = (rs1 == 5'd0) ? 64'd0 : regs[rs1];   // x0 reads zero
    assign rs2Val = (rs2 == 5'd0) ? 64'd0 : regs[rs2];

    assign opA = ctrl.selA ? rs1Val : instPc;
    assign opB = ctrl.selB ? rs2Val : ctrl.imm;
    assign aluOut = (ctrl.aluOperate == rvCorePkg::ALU_RETURN_B) ? opB : opA + opB;
    assign wbData = (ctrl.wbSel == rvCorePkg::WB_PC4) ? instPc + 64'd4 : aluOut;

    // a store holds the head until its write is granted
    assign active = instValid && !halted;
    assign retireValid = active && (!ctrl.isStore || bus.gnt);
    assign deq = retireValid;
    assign redirect = retireValid && ctrl.isJump;
    assign redirectPc = aluOut;

    assign retirePc = instPc;
    assign retireRd = rd;
    assign retireRdWe = retireValid && ctrl.writeRd && (rd != 5'd0);
    assign retireRdData = wbData;

    assign storeAddr = aluOut;
    assign storeMask = ctrl.storeMask << aluOut[2:0];
    assign storeData = rs2Val << {aluOut[2:0], 3'b000};
    assign storeValid = retireValid && ctrl.isStore;

    always_comb
    begin
        bus.req.req = active && ctrl.isStore;
        bus.req.we = 1'b1;
        bus.req.addr = aluOut[`MEM_AW+2:3];
        bus.req.wdata = storeData;
        bus.req.mask = storeMask;
    end

    always_ff @(posedge clk)
    begin
        if (retireRdWe)
            regs[rd] <= wbData;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            halted <= 1'b0;
        else if (retireValid && ctrl.isEbreak)
            halted <= 1'b1;   // sticky until reset
    end

endmodule

//--- verilog/memArbiter.sv
`timescale 1ns/10ps
`include "rvCoreParams.svh"

module memArbiter
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  logic               loadWe,
    input  logic [`MEM_AW-1:0] loadAddr,
    input  logic [63:0]        loadData,
    input  logic [63:0]        memRdata,
    memBusIf.arbiter           storeBus,
    memBusIf.arbiter           fetchBus,
    output logic               memEn,
    output logic               memWe,
    output logic [`MEM_AW-1:0] memAddr,
    output logic [63:0]        memWdata,
    output logic [7:0]         memMask
);

    logic loadGnt;
    logic storeGnt;
    logic fetchGnt;
    logic fetchRd;

    assign loadGnt = !run && loadWe;   // loader only while stopped
    assign storeGnt = !loadGnt && storeBus.req.req;
    assign fetchGnt = !loadGnt && !storeGnt && fetchBus.req.req;
    assign storeBus.gnt = storeGnt;
    assign fetchBus.gnt = fetchGnt;

    always_comb
    begin
        memEn = loadGnt || storeGnt || fetchGnt;
        if (loadGnt)
        begin
            memWe = 1'b1;
            memAddr = loadAddr;
            memWdata = loadData;
            memMask = 8'hff;
        end
        else if (storeGnt)
        begin
            memWe = storeBus.req.we;
            memAddr = storeBus.req.addr;
            memWdata = storeBus.req.wdata;
            memMask = storeBus.req.mask;
        end
        else
        begin
            memWe = fetchGnt && fetchBus.req.we;
            memAddr = fetchBus.req.addr;
            memWdata = fetchBus.req.wdata;
            memMask = fetchBus.req.mask;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            fetchRd <= 1'b0;
        else
            fetchRd <= fetchGnt && !fetchBus.req.we;
    end

    assign fetchBus.rdata = fetchRd ? memRdata : 64'd0;
    assign storeBus.rdata = 64'd0;   // write-only peer

endmodule

//--- verilog/unifiedMem.sv
`timescale 1ns/10ps
`include "rvCoreParams.svh"

module unifiedMem
(
    input  logic               clk,
    input  logic               memEn,
    input  logic               memWe,
    input  logic [`MEM_AW-1:0] memAddr,
    input  logic [63:0]        memWdata,
    input  logic [7:0]         memMask,
    output logic [63:0]        memRdata
);

    logic [63:0] mem [1 << `MEM_AW];

    always_ff @(posedge clk)
    begin
        if (memEn && memWe)
        begin
            for (int i = 0; i < 8; i++)
            begin
                if (memMask[i])
                    mem[memAddr][i*8 +: 8] <= memWdata[i*8 +: 8];
            end
        end
        else if (memEn)
            memRdata <= mem[memAddr];   // holds between reads
    end

endmodule

//--- verilog/rvCoreTop.sv
`timescale 1ns/10ps
`include "rvCoreParams.svh"

module rvCoreTop
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               run,
    input  logic               loadWe,
    input  logic [`MEM_AW-1:0] loadAddr,
    input  logic [63:0]        loadData,
    output logic               retireValid,
    output logic [63:0]        retirePc,
    output logic               retireRdWe,
    output logic [4:0]         retireRd,
    output logic [63:0]        retireRdData,
    output logic               storeValid,
    output logic [63:0]        storeAddr,
    output logic [63:0]        storeData,
    output logic [7:0]         storeMask,
    output logic               halted
);

    logic               instValid;
    logic [31:0]        instWord;
    logic [63:0]        instPc;
    logic               deq;
    logic               redirect;
    logic [63:0]        redirectPc;
    logic               memEn;
    logic               memWe;
    logic [`MEM_AW-1:0] memAddr;
    logic [63:0]        memWdata;
    logic [7:0]         memMask;
    logic [63:0]        memRdata;

    memBusIf storeBus ();
    memBusIf fetchBus ();

    fetchUnit fetch
    (
        .clk        (clk),
        .rstN       (rstN),
        .run        (run),
        .halted     (halted),
        .deq        (deq),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instValid  (instValid),
        .instWord   (instWord),
        .instPc     (instPc),
        .bus        (fetchBus)
    );

    execUnit exec
    (
        .clk          (clk),
        .rstN         (rstN),
        .instValid    (instValid),
        .instWord     (instWord),
        .instPc       (instPc),
        .deq          (deq),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .halted       (halted),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRdWe   (retireRdWe),
        .retireRd     (retireRd),
        .retireRdData (retireRdData),
        .storeValid   (storeValid),
        .storeAddr    (storeAddr),
        .storeData    (storeData),
        .storeMask    (storeMask),
        .bus          (storeBus)
    );

    memArbiter arbiter
    (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .loadWe   (loadWe),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .memRdata (memRdata),
        .storeBus (storeBus),
        .fetchBus (fetchBus),
        .memEn    (memEn),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memMask  (memMask)
    );

    unifiedMem mem
    (
        .clk      (clk),
        .memEn    (memEn),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memMask  (memMask),
        .memRdata (memRdata)
    );

endmodule

//--- dv/rvCore_asserts.sv
`timescale 1ns/10ps

module rvCoreAsserts
(
    input logic       clk,
    input logic       rstN,
    input logic       retireValid,
    input logic       storeValid,
    input logic [7:0] storeMask,
    input logic       halted,
    input logic       fetchGnt,
    input logic       storeReq,
    input logic       fetchReq,
    input logic       memEn,
    input logic       memWe,
    input logic [7:0] memMask
);

    // the store owns the memory port in its retire cycle
    noStoreWhileFetch: assert property (@(posedge clk) disable iff (!rstN)
        storeValid |-> memEn && memWe && !fetchGnt && (memMask == storeMask))
        else $error("store retired without owning the memory write port");

    // halted core leaves the memory idle as well
    noRetireAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !retireValid && !storeValid && !memEn)
        else $error("instruction retired or memory accessed after halt");

    quietAfterReset: assert property (@(posedge clk)
        !rstN |=> !retireValid && !storeValid && !halted && !storeReq && !fetchReq)
        else $error("outputs or request strobes active right after reset");

endmodule

bind rvCoreTop rvCoreAsserts asserts
(
    .clk         (clk),
    .rstN        (rstN),
    .retireValid (retireValid),
    .storeValid  (storeValid),
    .storeMask   (storeMask),
    .halted      (halted),
    .fetchGnt    (fetchBus.gnt),
    .storeReq    (storeBus.req.req),
    .fetchReq    (fetchBus.req.req),
    .memEn       (memEn),
    .memWe       (memWe),
    .memMask     (memMask)
);

//--- dv/rvCoreTb.sv
`timescale 1ns/10ps
`include "rvCoreParams.svh"

module rvCoreTb;

    localparam int NumProgs = 6;
    localparam int ProgLen = 128;          // instruction slots, two per memory word
    localparam int ProgWords = ProgLen / 2;
    localparam int ResetCycles = 8;
    localparam int TimeoutCycles = NumProgs * (ResetCycles + ProgWords + 4 * ProgLen + 20) + 100;

    typedef struct packed {
        logic [63:0] pc;
        logic        rdWe;
        logic [4:0]  rd;
        logic [63:0] rdData;
        logic        store;
        logic [63:0] stAddr;
        logic [63:0] stData;
        logic [7:0]  stMask;
    } retireRec_t;

    logic               clk;
    logic               rstN;
    logic               run;
    logic               loadWe;
    logic [`MEM_AW-1:0] loadAddr;
    logic [63:0]        loadData;
    logic               retireValid;
    logic [63:0]        retirePc;
    logic               retireRdWe;
    logic [4:0]         retireRd;
    logic [63:0]        retireRdData;
    logic               storeValid;
    logic [63:0]        storeAddr;
    logic [63:0]        storeData;
    logic [7:0]         storeMask;
    logic               halted;

    logic [31:0] rngState = 32'h34dd_bedc;
    logic [31:0] prog [ProgLen];
    logic [63:0] modelRegs [32];
    retireRec_t  expQ [$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    rvCoreTop uut
    (
        .clk          (clk),
        .rstN         (rstN),
        .run          (run),
        .loadWe       (loadWe),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRdWe   (retireRdWe),
        .retireRd     (retireRd),
        .retireRdData (retireRdData),
        .storeValid   (storeValid),
        .storeAddr    (storeAddr),
        .storeData    (storeData),
        .storeMask    (storeMask),
        .halted       (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] s;
        s = rngState;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rngState = s;
        return s;
    endfunction

    function automatic logic [31:0] rTypeWord(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] uTypeWord(input logic [6:0] op, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jTypeWord(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] sTypeWord(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] randomAluInst();
        logic [31:0] r;
        r = nextRandom();
        case (r[1:0])
            2'd0:    return rTypeWord(r[6:2], r[11:7], r[16:12]);
            2'd1:    return iTypeWord(r[6:2], r[11:7], r[31:20]);
            2'd2:    return uTypeWord(7'b0110111, r[6:2], r[31:12]);
            default: return uTypeWord(7'b0010111, r[6:2], r[31:12]);
        endcase
    endfunction

    // x0 based, lands in bytes 0x400..0x7ff, clear of the program
    function automatic logic [31:0] randomStoreInst();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        r = nextRandom();
        f3 = {1'b0, r[1:0]};
        imm = {2'b01, r[8:2], 3'b000};
        case (f3)
            3'd0:    imm[2:0] = r[11:9];
            3'd1:    imm[2:0] = {r[11:10], 1'b0};
            3'd2:    imm[2:0] = {r[11], 2'b00};
            default: imm[2:0] = 3'b000;
        endcase
        return sTypeWord(f3, 5'd0, r[16:12], imm);
    endfunction

    task automatic checkValue(input string what, input logic [63:0] got, input logic [63:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic buildProgram();
        int          n;
        int          gap;
        logic [31:0] r;
        n = 0;
        for (int i = 1; i < 32; i++)
        begin
            r = nextRandom();
            prog[n] = iTypeWord(5'(i), 5'd0, r[11:0]);   // every register gets a value
            n++;
        end
        while (n < ProgLen - 8)
        begin
            r = nextRandom();
            case (r[2:0])
                3'd4, 3'd5:
                begin
                    prog[n] = randomStoreInst();
                    n++;
                end
                3'd6:
                begin
                    gap = 1 + (r[4:3] % 3);
                    prog[n] = jTypeWord(r[9:5], 21'(4 * (gap + 1)));
                    n++;
                    for (int k = 0; k < gap; k++)
                    begin
                        prog[n] = randomAluInst();   // skipped, must never retire
                        n++;
                    end
                end
                3'd7:
                begin
                    for (int k = 0; k < 4; k++)
                    begin
                        prog[n] = randomStoreInst();   // burst against prefetch
                        n++;
                    end
                end
                default:
                begin
                    prog[n] = randomAluInst();
                    n++;
                end
            endcase
        end
        prog[n] = 32'h0010_0073;   // ebreak
        n++;
        while (n < ProgLen)
        begin
            prog[n] = randomAluInst();
            n++;
        end
    endtask

    task automatic runModel();
        logic [63:0] pc;
        logic [31:0] inst;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] addr;
        logic [7:0]  sizeMask;
        logic        writes;
        logic        done;
        retireRec_t  rec;
        int          steps;
        pc = `RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < ProgLen)
        begin
            inst = prog[pc[8:2]];
            a = modelRegs[inst[19:15]];
            b = modelRegs[inst[24:20]];
            rec = '0;
            rec.pc = pc;
            rec.rd = inst[11:7];
            writes = 1'b1;
            case (inst[6:0])
                7'b0110011: rec.rdData = a + b;
                7'b0010011: rec.rdData = a + {{52{inst[31]}}, inst[31:20]};
                7'b0110111: rec.rdData = {{32{inst[31]}}, inst[31:12], 12'h000};
                7'b0010111: rec.rdData = pc + {{32{inst[31]}}, inst[31:12], 12'h000};
                7'b1101111: rec.rdData = pc + 64'd4;
                7'b0100011:
                begin
                    writes = 1'b0;
                    addr = a + {{52{inst[31]}}, inst[31:25], inst[11:7]};
                    case (inst[14:12])
                        3'd0:    sizeMask = 8'h01;
                        3'd1:    sizeMask = 8'h03;
                        3'd2:    sizeMask = 8'h0f;
                        default: sizeMask = 8'hff;
                    endcase
                    rec.store = 1'b1;
                    rec.stAddr = addr;
                    rec.stMask = sizeMask << addr[2:0];
                    rec.stData = b << {addr[2:0], 3'b000};
                end
                default:
                begin
                    writes = 1'b0;   // ebreak ends the program
                    done = 1'b1;
                end
            endcase
            rec.rdWe = writes && (rec.rd != 5'd0);
            if (rec.rdWe)
                modelRegs[rec.rd] = rec.rdData;
            expQ.push_back(rec);
            if (inst[6:0] == 7'b1101111)
                pc = pc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            else
                pc = pc + 64'd4;
            steps++;
        end
    endtask

    task automatic applyReset();
        @(negedge clk);
        rstN <= 1'b0;
        repeat (ResetCycles) @(negedge clk);
        rstN <= 1'b1;
    endtask

    task automatic loadProgram();
        for (int w = 0; w < ProgWords; w++)
        begin
            @(negedge clk);
            loadWe <= 1'b1;
            loadAddr <= w[`MEM_AW-1:0];
            loadData <= {prog[2*w+1], prog[2*w]};
        end
        @(negedge clk);
        loadWe <= 1'b0;
    endtask

    // outputs settle after the rising edge, so the falling edge sees them stable
    always @(negedge clk)
    begin : retireMonitor
        retireRec_t want;
        if (rstN && retireValid)
        begin
            if (expQ.size() == 0)
            begin
                errors++;
                $display("Error at %0t: retire at pc %h after the program ended", $time, retirePc);
            end
            else
            begin
                want = expQ.pop_front();
                checkValue("retirePc", retirePc, want.pc);
                checkValue("retireRdWe", 64'(retireRdWe), 64'(want.rdWe));
                if (want.rdWe)
                begin
                    checkValue("retireRd", 64'(retireRd), 64'(want.rd));
                    checkValue("retireRdData", retireRdData, want.rdData);
                end
                checkValue("storeValid", 64'(storeValid), 64'(want.store));
                if (want.store)
                begin
                    checkValue("storeAddr", storeAddr, want.stAddr);
                    checkValue("storeData", storeData, want.stData);
                    checkValue("storeMask", 64'(storeMask), 64'(want.stMask));
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles)
        begin
            $display("Timeout: the core did not halt within %0d cycles", TimeoutCycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial
    begin
        rstN <= 1'b0;
        run <= 1'b0;
        loadWe <= 1'b0;
        loadAddr <= '0;
        loadData <= '0;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = 64'd0;
        for (int p = 0; p < NumProgs; p++)
        begin
            buildProgram();
            runModel();
            applyReset();
            loadProgram();
            @(negedge clk);
            run <= 1'b1;
            while (!halted)
                @(negedge clk);
            repeat (5) @(negedge clk);   // window for stray retires after halt
            checkValue("instructions never retired", 64'(expQ.size()), 64'd0);
            expQ.delete();
            run <= 1'b0;
        end
        $display("Finished %0d programs: %0d checks, %0d errors", NumProgs, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- rvCore.f
+incdir+verilog
verilog/rvCorePkg.sv
verilog/memBusIf.sv
verilog/instDecoder.sv
verilog/fetchUnit.sv
verilog/execUnit.sv
verilog/memArbiter.sv
verilog/unifiedMem.sv
verilog/rvCoreTop.sv
dv/rvCore_asserts.sv
dv/rvCoreTb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rvCore testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f rvCore.f --top-module rvCoreTb -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rvCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
